/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // bus data word and byte address
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] haddr_t;

  // ------------------------------------------------------------------------
  // bus structs
  // ------------------------------------------------------------------------
  // master request, valid in the hsel cycle
  typedef struct packed {
    haddr_t haddr;
    logic   hwrite;
    data_t  hwdata;
  } mas_send_type;

  // slave response, hreadyout is a one cycle strobe
  typedef struct packed {
    logic  hreadyout;
    logic  hresp;
    data_t hrdata;
  } slv_send_type;

  // ------------------------------------------------------------------------
  // configuration
  // ------------------------------------------------------------------------
  // what the port front-ends see
  typedef struct packed {
    haddr_t base;
    logic   write_en;
  } mem_cfg_t;

  // register offsets on the strobe port
  localparam logic CFG_REG_BASE = 1'b0;
  localparam logic CFG_REG_CTRL = 1'b1;

  // values after reset
  localparam haddr_t CFG_BASE_RST = 32'h0000_0400;
  localparam logic   CFG_WEN_RST  = 1'b1;

endpackage

`default_nettype wire

/* mem_dp_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_dp_sram
#(
  parameter int MEM_WORDS = 256
)
(
  input  wire logic                         clk_l2,
  // port a, read only
  input  wire logic [$clog2(MEM_WORDS)-1:0] a_addr,
  output mem_pkg::data_t                    a_rdata,
  // port b, read and write
  input  wire logic [$clog2(MEM_WORDS)-1:0] b_addr,
  input  wire logic                         b_wen,
  input  wire mem_pkg::data_t               b_wdata,
  output mem_pkg::data_t                    b_rdata
);

  import mem_pkg::*;

  // word array, contents undefined until written
  data_t mem [MEM_WORDS];

  // ------------------------------------------------------------------------
  // port a
  // ------------------------------------------------------------------------
  // registered read
  // same word written on b this edge still gives old data here
  always_ff @(posedge clk_l2)
  begin
    a_rdata <= mem[a_addr];
  end

  // ------------------------------------------------------------------------
  // port b
  // ------------------------------------------------------------------------
  // write returns the written word on the read bus
  always_ff @(posedge clk_l2)
  begin
    if (b_wen)
    begin
      mem[b_addr] <= b_wdata;
      b_rdata     <= b_wdata;
    end
    else
    begin
      b_rdata <= mem[b_addr];
    end
  end

endmodule

`default_nettype wire

/* mem_ahb_port.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ahb_port
#(
  parameter int MEM_WORDS = 256,
  parameter bit WRITABLE  = 1'b1
)
(
  input  wire logic                         clk_l2,
  input  wire logic                         rst_n,
  // bus side
  input  wire logic                         hsel,
  input  wire mem_pkg::mas_send_type        req,
  output mem_pkg::slv_send_type             rsp,
  // from the register block
  input  wire mem_pkg::mem_cfg_t            cfg,
  // sram side
  output logic [$clog2(MEM_WORDS)-1:0]      ram_addr,
  output logic                              ram_wen,
  output mem_pkg::data_t                    ram_wdata,
  input  wire mem_pkg::data_t               ram_rdata
);

  import mem_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  // one valid bit per stage
  logic         s1_vld;
  logic         s2_vld;
  logic         s3_vld;
  logic         busy;
  // latched request
  mas_send_type req_q;
  // address check
  haddr_t       offset;
  logic         below_base;
  logic         misaligned;
  logic         out_of_range;
  logic         wr_denied;
  logic         req_err;
  // error status riding along the pipe
  logic         err_s2;
  logic         err_s3;

  // ------------------------------------------------------------------------
  // request / acknowledge sequencer
  // ------------------------------------------------------------------------
  // port stays busy until the response is registered
  assign busy = s1_vld | s2_vld | s3_vld;

  // edge 0 accepts, edges 1 to 3 walk the pipe
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      s3_vld <= 1'b0;
    end
    else
    begin
      s1_vld <= hsel & ~busy;
      s2_vld <= s1_vld;
      s3_vld <= s2_vld;
    end
  end

  // request latch, hsel while busy is dropped
  always_ff @(posedge clk_l2)
  begin
    if (hsel && !busy)
      req_q <= req;
  end

  // ------------------------------------------------------------------------
  // address translation and checks
  // ------------------------------------------------------------------------
  // byte offset from the base
  assign offset       = req_q.haddr - cfg.base;
  assign below_base   = req_q.haddr < cfg.base;
  assign misaligned   = |req_q.haddr[1:0];
  // word index past the array end
  assign out_of_range = offset[ADDR_W-1:2] >= (ADDR_W-2)'(MEM_WORDS);
  // write on a read only port or while writes are disabled
  assign wr_denied    = req_q.hwrite & (~WRITABLE | ~cfg.write_en);
  assign req_err      = below_base | misaligned | out_of_range | wr_denied;

  // edge 1, issue the sram access
  // a bad request never writes
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ram_wen <= 1'b0;
      err_s2  <= 1'b0;
    end
    else
    begin
      ram_wen <= s1_vld & req_q.hwrite & ~req_err;
      err_s2  <= req_err;
    end
  end

  // sram address and write word
  always_ff @(posedge clk_l2)
  begin
    if (s1_vld)
    begin
      ram_addr  <= offset[IDX_W+1:2];
      ram_wdata <= req_q.hwdata;
    end
  end

  // edge 2, sram completes
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
      err_s3 <= 1'b0;
    else
      err_s3 <= err_s2;
  end

  // ------------------------------------------------------------------------
  // response register
  // ------------------------------------------------------------------------
  // edge 3, one cycle strobe
  // error gives hresp 1 with zero data
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rsp <= '0;
    end
    else
    begin
      rsp.hreadyout <= s3_vld;
      rsp.hresp     <= s3_vld & err_s3;
      rsp.hrdata    <= (s3_vld && !err_s3) ? ram_rdata : '0;
    end
  end

endmodule

`default_nettype wire

/* mem_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_cfg_regs
(
  input  wire logic            clk_l2,
  input  wire logic            rst_n,
  // strobe port
  input  wire logic            cfg_wr,
  input  wire logic            cfg_sel,
  input  wire mem_pkg::data_t  cfg_wdata,
  output mem_pkg::data_t       cfg_rdata,
  // to the port front-ends
  output mem_pkg::mem_cfg_t    cfg
);

  import mem_pkg::*;

  haddr_t base_q;
  logic   wen_q;

  // ------------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------------
  // base kept word aligned
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      base_q <= CFG_BASE_RST;
      wen_q  <= CFG_WEN_RST;
    end
    else if (cfg_wr)
    begin
      if (cfg_sel == CFG_REG_BASE)
        base_q <= {cfg_wdata[DATA_W-1:2], 2'b00};
      else
        wen_q <= cfg_wdata[0];
    end
  end

  // ------------------------------------------------------------------------
  // readback and outputs
  // ------------------------------------------------------------------------
  // ctrl reads back with write enable in bit 0
  always_comb
  begin
    if (cfg_sel == CFG_REG_CTRL)
      cfg_rdata = {{(DATA_W-1){1'b0}}, wen_q};
    else
      cfg_rdata = base_q;
  end

  // no extra latency toward the ports
  assign cfg.base     = base_q;
  assign cfg.write_en = wen_q;

endmodule

`default_nettype wire

/* renas_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module renas_memory
#(
  parameter int MEM_WORDS = 256
)
(
  input  wire logic                   clk_l2,
  input  wire logic                   rst_n,
  // instruction bus
  input  wire logic                   imem_hsel,
  input  wire mem_pkg::mas_send_type  imem_in,
  output mem_pkg::slv_send_type       imem_out,
  // data bus
  input  wire logic                   dmem_hsel,
  input  wire mem_pkg::mas_send_type  dmem_in,
  output mem_pkg::slv_send_type       dmem_out,
  // configuration strobe port
  input  wire logic                   cfg_wr,
  input  wire logic                   cfg_sel,
  input  wire mem_pkg::data_t         cfg_wdata,
  output mem_pkg::data_t              cfg_rdata
);

  import mem_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  // shared configuration
  mem_cfg_t         cfg;
  // instruction side of the sram
  logic [IDX_W-1:0] i_addr;
  data_t            i_rdata;
  // data side of the sram
  logic [IDX_W-1:0] d_addr;
  logic             d_wen;
  data_t            d_wdata;
  data_t            d_rdata;

  // ------------------------------------------------------------------------
  // configuration block
  // ------------------------------------------------------------------------
  mem_cfg_regs u_cfg
  (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .cfg       (cfg)
  );

  // ------------------------------------------------------------------------
  // bus front-ends
  // ------------------------------------------------------------------------
  // instruction port, reads only so write side left open
  mem_ahb_port
  #(
    .MEM_WORDS (MEM_WORDS),
    .WRITABLE  (1'b0)
  )
  u_iport
  (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .hsel      (imem_hsel),
    .req       (imem_in),
    .rsp       (imem_out),
    .cfg       (cfg),
    .ram_addr  (i_addr),
    .ram_wen   (),
    .ram_wdata (),
    .ram_rdata (i_rdata)
  );

  // data port
  mem_ahb_port
  #(
    .MEM_WORDS (MEM_WORDS),
    .WRITABLE  (1'b1)
  )
  u_dport
  (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .hsel      (dmem_hsel),
    .req       (dmem_in),
    .rsp       (dmem_out),
    .cfg       (cfg),
    .ram_addr  (d_addr),
    .ram_wen   (d_wen),
    .ram_wdata (d_wdata),
    .ram_rdata (d_rdata)
  );

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------
  // port a for fetch, port b for load and store
  mem_dp_sram
  #(
    .MEM_WORDS (MEM_WORDS)
  )
  u_sram
  (
    .clk_l2  (clk_l2),
    .a_addr  (i_addr),
    .a_rdata (i_rdata),
    .b_addr  (d_addr),
    .b_wen   (d_wen),
    .b_wdata (d_wdata),
    .b_rdata (d_rdata)
  );

endmodule

`default_nettype wire

/* mem_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_checker
(
  input  wire logic                  clk_l2,
  input  wire logic                  rst_n,
  input  wire logic                  imem_hsel,
  input  wire logic                  dmem_hsel,
  input  wire mem_pkg::slv_send_type imem_out,
  input  wire mem_pkg::slv_send_type dmem_out,
  input  wire mem_pkg::data_t        cfg_rdata
);

  import mem_pkg::*;

  // hreadyout rises after the third edge, first seen on the fourth
  localparam int unsigned LAT_SEEN = 4;

  // expected {hresp, hrdata} per port, oldest first
  logic [32:0] exp_i [$];
  logic [32:0] exp_d [$];
  // cycle each hsel was sampled
  int unsigned iss_i [$];
  int unsigned iss_d [$];
  int unsigned cyc       = 0;
  int unsigned lat       = 0;
  int          err_count = 0;
  int          test_errs = 0;
  int          test_num  = 0;
  int          n_rsp     = 0;
  logic        rdy_i_q   = 1'b0;
  logic        rdy_d_q   = 1'b0;

  // ------------------------------------------------------------------------
  // reporting
  // ------------------------------------------------------------------------
  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    err_count++;
    test_errs++;
  endtask

  // protocol and timing trouble, not a data mismatch
  task automatic report_fail(input string msg);
    $display("failure at %0t ns: %s", $time, msg);
    err_count++;
    test_errs++;
  endtask

  task automatic push_expect(input logic dport, input logic [32:0] exp);
    if (dport)
      exp_d.push_back(exp);
    else
      exp_i.push_back(exp);
  endtask

  task automatic compare_rsp(input string port, input slv_send_type rsp,
                             input logic [32:0] exp, input int unsigned lat_seen);
    n_rsp++;
    if (lat_seen != LAT_SEEN)
      report_fail($sformatf("%s response took %0d cycles from hsel instead of %0d",
                            port, lat_seen, LAT_SEEN));
    if ({rsp.hresp, rsp.hrdata} !== exp)
      report_error($sformatf("%s got hresp %0b hrdata %08h, expected hresp %0b hrdata %08h",
                             port, rsp.hresp, rsp.hrdata, exp[32], exp[31:0]));
  endtask

  // cfg_rdata is combinational, caller samples after it settles
  task automatic check_cfg(input data_t exp, input string what);
    if (cfg_rdata !== exp)
      report_error($sformatf("%s read %08h, expected %08h", what, cfg_rdata, exp));
  endtask

  task automatic end_test(input string name);
    // past the edge that compares the last response
    @(negedge clk_l2);
    test_num++;
    $display("test %0d %-10s %s with %0d errors", test_num, name,
             (test_errs == 0) ? "passed" : "failed", test_errs);
    test_errs = 0;
  endtask

  task automatic summary();
    if (exp_i.size() != 0 || exp_d.size() != 0)
      report_fail($sformatf("%0d responses never arrived", exp_i.size() + exp_d.size()));
    $display("totals: %0d tests, %0d responses checked, %0d errors",
             test_num, n_rsp, err_count);
  endtask

  // ------------------------------------------------------------------------
  // response monitor
  // ------------------------------------------------------------------------
  // posedge sees the registered outputs from before this edge
  always @(posedge clk_l2)
  begin
    cyc = cyc + 1;
    if (rst_n)
    begin
      if (imem_hsel)
        iss_i.push_back(cyc);
      if (dmem_hsel)
        iss_d.push_back(cyc);
      // instruction port
      if (imem_out.hreadyout)
      begin
        lat = (iss_i.size() != 0) ? cyc - iss_i.pop_front() : 0;
        if (exp_i.size() == 0)
          report_fail("imem raised hreadyout with no request outstanding");
        else
          compare_rsp("imem", imem_out, exp_i.pop_front(), lat);
      end
      // data port
      if (dmem_out.hreadyout)
      begin
        lat = (iss_d.size() != 0) ? cyc - iss_d.pop_front() : 0;
        if (exp_d.size() == 0)
          report_fail("dmem raised hreadyout with no request outstanding");
        else
          compare_rsp("dmem", dmem_out, exp_d.pop_front(), lat);
      end
      // strobe must drop after one cycle
      if (imem_out.hreadyout && rdy_i_q)
        report_fail("imem hreadyout stayed high for more than one cycle");
      if (dmem_out.hreadyout && rdy_d_q)
        report_fail("dmem hreadyout stayed high for more than one cycle");
      rdy_i_q = imem_out.hreadyout;
      rdy_d_q = dmem_out.hreadyout;
    end
  end

endmodule

`default_nettype wire

/* tb_renas_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_renas_memory;

  import mem_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int N_READ    = 200;
  localparam int N_ERR     = 64;
  localparam int N_CFG     = 48;
  localparam int N_CONC    = 300;
  // each transaction needs about 6 cycles, budget 8 plus margin
  localparam int N_TRANS   = MEM_WORDS + N_READ + N_ERR + N_CFG + N_CONC;
  localparam int LIMIT_NS  = (N_TRANS * 8 + 200) * 20;

  logic         clk_l2;
  logic         rst_n;
  logic         imem_hsel;
  mas_send_type imem_in;
  slv_send_type imem_out;
  logic         dmem_hsel;
  mas_send_type dmem_in;
  slv_send_type dmem_out;
  logic         cfg_wr;
  logic         cfg_sel;
  data_t        cfg_wdata;
  data_t        cfg_rdata;
  // reference model of array and config
  data_t        model [MEM_WORDS];
  haddr_t       m_base;
  logic         m_wen;
  int unsigned  seed;

  // ------------------------------------------------------------------------
  // clock, DUT and checker
  // ------------------------------------------------------------------------
  initial
  begin
    clk_l2 = 1'b0;
    forever #10 clk_l2 = ~clk_l2;
  end

  renas_memory #(.MEM_WORDS(MEM_WORDS)) dut0
  (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .imem_hsel (imem_hsel),
    .imem_in   (imem_in),
    .imem_out  (imem_out),
    .dmem_hsel (dmem_hsel),
    .dmem_in   (dmem_in),
    .dmem_out  (dmem_out),
    .cfg_wr    (cfg_wr),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  mem_checker chk0
  (
    .clk_l2    (clk_l2),
    .rst_n     (rst_n),
    .imem_hsel (imem_hsel),
    .dmem_hsel (dmem_hsel),
    .imem_out  (imem_out),
    .dmem_out  (dmem_out),
    .cfg_rdata (cfg_rdata)
  );

  // watchdog
  initial
  begin
    #(LIMIT_NS);
    $display("run hung, watchdog expired after %0d ns waiting for a response", LIMIT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------
  // returns {hresp, hrdata}, updates the array on a good write
  function automatic logic [32:0] predict(input haddr_t addr, input logic write,
                                          input data_t wdata, input logic writable);
    haddr_t off;
    logic   err;
    off = addr - m_base;
    err = (addr < m_base) || (addr[1:0] != 2'b00) || ((off >> 2) >= MEM_WORDS) ||
          (write && !(writable && m_wen));
    if (err)
      return {1'b1, 32'h0};
    if (write)
    begin
      model[off >> 2] = wdata;
      return {1'b0, wdata};
    end
    return {1'b0, model[off >> 2]};
  endfunction

  function automatic haddr_t word_addr(input int unsigned idx);
    return m_base + (idx << 2);
  endfunction

  // ------------------------------------------------------------------------
  // bus and config drivers
  // ------------------------------------------------------------------------
  // one request per enabled port in the same cycle, waits for both replies
  task automatic access(input logic do_i, input haddr_t ia, input logic iw,
                        input logic do_d, input haddr_t da, input logic dw, input data_t dd);
    logic  i_done;
    logic  d_done;
    data_t iwd;
    iwd = $urandom;
    @(negedge clk_l2);
    // fetch sees the word before a same cycle store
    if (do_i)
      chk0.push_expect(1'b0, predict(ia, iw, iwd, 1'b0));
    if (do_d)
      chk0.push_expect(1'b1, predict(da, dw, dd, 1'b1));
    imem_hsel = do_i;
    imem_in   = {ia, iw, iwd};
    dmem_hsel = do_d;
    dmem_in   = {da, dw, dd};
    @(negedge clk_l2);
    imem_hsel = 1'b0;
    dmem_hsel = 1'b0;
    i_done    = !do_i;
    d_done    = !do_d;
    while (!(i_done && d_done))
    begin
      @(posedge clk_l2);
      i_done = i_done | imem_out.hreadyout;
      d_done = d_done | dmem_out.hreadyout;
    end
  endtask

  task automatic cfg_write(input logic sel, input data_t value);
    @(negedge clk_l2);
    cfg_wr    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = value;
    @(negedge clk_l2);
    cfg_wr = 1'b0;
    if (sel == CFG_REG_BASE)
      m_base = {value[31:2], 2'b00};
    else
      m_wen = value[0];
  endtask

  task automatic cfg_expect(input logic sel, input data_t exp, input string what);
    @(negedge clk_l2);
    cfg_sel = sel;
    @(posedge clk_l2);
    chk0.check_cfg(exp, what);
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial
  begin
    haddr_t a;
    int     k;
    seed = 38047;
    void'($urandom(seed));
    imem_hsel = 1'b0;
    imem_in   = '0;
    dmem_hsel = 1'b0;
    dmem_in   = '0;
    cfg_wr    = 1'b0;
    cfg_sel   = CFG_REG_BASE;
    cfg_wdata = '0;
    m_base    = CFG_BASE_RST;
    m_wen     = CFG_WEN_RST;
    rst_n     = 1'b0;
    repeat (10) @(posedge clk_l2);
    @(negedge clk_l2);
    rst_n = 1'b1;

    // idle, checker flags any stray hreadyout
    repeat (5) @(posedge clk_l2);
    cfg_expect(CFG_REG_BASE, 32'h0000_0400, "base after reset");
    cfg_expect(CFG_REG_CTRL, 32'h0000_0001, "write enable after reset");
    chk0.end_test("reset");

    // fill every word, then read back on alternating ports
    for (k = 0; k < MEM_WORDS; k++)
      access(1'b0, 32'h0, 1'b0, 1'b1, word_addr(k), 1'b1, $urandom);
    for (k = 0; k < N_READ; k++)
    begin
      a = word_addr($urandom % MEM_WORDS);
      access(k % 2 == 0, a, 1'b0, k % 2 == 1, a, 1'b0, 32'h0);
    end
    chk0.end_test("readback");

    // misaligned, below base, past the end, fetch side store
    for (k = 0; k < N_ERR - 16; k++)
    begin
      case (k % 4)
        0: a = word_addr($urandom % MEM_WORDS) + 1 + ($urandom % 3);
        1: a = m_base - 4 * (1 + ($urandom % 16));
        2: a = m_base + 4 * MEM_WORDS + 4 * ($urandom % 16);
        default: a = word_addr($urandom % MEM_WORDS);
      endcase
      if (k % 4 == 3)
        access(1'b1, a, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0);
      else
        access(1'b0, 32'h0, 1'b0, 1'b1, a, $urandom % 2, $urandom);
    end
    // array must be untouched
    for (k = 0; k < 16; k++)
      access(1'b0, 32'h0, 1'b0, 1'b1, word_addr($urandom % MEM_WORDS), 1'b0, 32'h0);
    chk0.end_test("errors");

    // stores blocked while write enable is off
    cfg_write(CFG_REG_CTRL, 32'h0);
    cfg_expect(CFG_REG_CTRL, {31'b0, m_wen}, "write enable cleared");
    for (k = 0; k < N_CFG / 2; k++)
    begin
      // blocked store, then a read of the same word
      if (k % 2 == 0)
        a = word_addr($urandom % MEM_WORDS);
      access(1'b0, 32'h0, 1'b0, 1'b1, a, k % 2 == 0, $urandom);
    end
    cfg_write(CFG_REG_CTRL, 32'h1);
    // low bits of the new base are dropped
    cfg_write(CFG_REG_BASE, $urandom & 32'h0fff_ffff);
    cfg_expect(CFG_REG_BASE, m_base, "moved base");
    for (k = 0; k < N_CFG / 2; k++)
    begin
      a = word_addr($urandom % MEM_WORDS);
      access(k % 2 == 0, a, 1'b0, k % 2 == 1, a, $urandom % 2, $urandom);
    end
    chk0.end_test("config");

    // both ports together, about a quarter on the same word
    for (k = 0; k < N_CONC; k++)
    begin
      a = word_addr($urandom % MEM_WORDS);
      access($urandom % 4 != 0, a, 1'b0, 1'b1,
             ($urandom % 4 == 0) ? a : word_addr($urandom % MEM_WORDS),
             $urandom % 2, $urandom);
    end
    chk0.end_test("concurrent");

    repeat (10) @(posedge clk_l2);
    chk0.summary();
    if (chk0.err_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
mem_pkg.sv
mem_dp_sram.sv
mem_ahb_port.sv
mem_cfg_regs.sv
renas_memory.sv
mem_checker.sv
tb_renas_memory.sv
